// ==== src.f ====
+incdir+hw
hw/displayPkg.sv
hw/regPkg.sv
hw/apbRegs.sv
hw/tftTiming.sv
hw/pixelScanner.sv
hw/rectLayer.sv
hw/layerMixer.sv
hw/overlayTop.sv
verif/overlay_checker.sv
verif/overlayTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the overlay testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module overlayTb -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

// ==== verif/overlayTb.sv ====
`timescale 1ns/1ns
`include "display_params.svh"

module overlayTb;

    localparam int LAYERS = `DISP_LAYERS;
    localparam int LINE   = `DISP_HBACK + `DISP_HDISP + `DISP_HFRONT;
    localparam int FRAME  = LINE * (`DISP_VBACK + `DISP_VDISP + `DISP_VFRONT);
    // Eight frames plus the register traffic around them
    localparam int CYCLE_LIMIT = 8 * FRAME + 400;

    logic CLK;
    logic RESET;
    logic pSel;
    logic pEnable;
    logic pWrite;
    regPkg::regAddrT pAddr;
    regPkg::regDataT pWData;
    regPkg::regDataT pRData;
    logic pSlvErr;
    logic hwDclk;
    logic hwDisp;
    logic hwVSync;
    logic hwHSync;
    displayPkg::colourT hwRgb;

    integer seed;
    int errors;
    int cycles;

    // Written configuration and the one the panel currently shows
    displayPkg::colourT pendBg;
    displayPkg::colourT actBg;
    logic [31:0] pendRect [LAYERS];
    logic [31:0] actRect [LAYERS];
    displayPkg::colourT pendColour [LAYERS];
    displayPkg::colourT actColour [LAYERS];
    logic pendEn [LAYERS];
    logic actEn [LAYERS];

    // Position on the panel as located from the sync outputs
    logic prevH;
    logic prevV;
    int hc;
    int lc;
    int frameNo;
    logic checkPixels;

    overlayTop dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .pSel    (pSel),
        .pEnable (pEnable),
        .pWrite  (pWrite),
        .pAddr   (pAddr),
        .pWData  (pWData),
        .pRData  (pRData),
        .pSlvErr (pSlvErr),
        .hwDclk  (hwDclk),
        .hwDisp  (hwDisp),
        .hwVSync (hwVSync),
        .hwHSync (hwHSync),
        .hwRgb   (hwRgb)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // Panel clock output mirrors the system clock in both phases
    always @(CLK) begin
        #1;
        assert (hwDclk == CLK) else begin
            errors++;
            $display("FAILED at %0t: hwDclk %b while CLK is %b", $time, hwDclk, CLK);
        end
    end

    function automatic regPkg::regAddrT layerAddr(input int i, input int offs);
        return regPkg::regAddrT'(`REG_LAYER_BASE + i * `REG_LAYER_STRIDE + offs);
    endfunction

    // Inclusive bounds with x0 y0 x1 y1 from byte 0 up
    function automatic logic covers(input logic [31:0] rect, input int x, input int y);
        return x >= int'(rect[7:0]) && x <= int'(rect[23:16]) &&
               y >= int'(rect[15:8]) && y <= int'(rect[31:24]);
    endfunction

    function automatic displayPkg::colourT refColour(input int x, input int y);
        displayPkg::colourT c;
        c = actBg;
        for (int i = 0; i < LAYERS; i++) begin
            if (actEn[i] && covers(actRect[i], x, y)) begin
                c = actColour[i];
            end
        end
        return c;
    endfunction

    function automatic logic pendOverlap();
        int n;
        logic found;
        found = 1'b0;
        for (int y = 0; y < `DISP_VDISP; y++) begin
            for (int x = 0; x < `DISP_HDISP; x++) begin
                n = 0;
                for (int i = 0; i < LAYERS; i++) begin
                    if (pendEn[i] && covers(pendRect[i], x, y)) begin
                        n++;
                    end
                end
                if (n > 1) begin
                    found = 1'b1;
                end
            end
        end
        return found;
    endfunction

    // Sorted corners inside the visible area
    function automatic logic [31:0] randRect();
        logic [31:0] r;
        logic [7:0] xa;
        logic [7:0] xb;
        logic [7:0] ya;
        logic [7:0] yb;
        r = $random(seed);
        xa = {4'd0, r[3:0]};
        xb = {4'd0, r[7:4]};
        ya = {5'd0, r[10:8]};
        yb = {5'd0, r[13:11]};
        return {(ya > yb ? ya : yb), (xa > xb ? xa : xb),
                (ya > yb ? yb : ya), (xa > xb ? xb : xa)};
    endfunction

    function automatic displayPkg::colourT randColour();
        logic [31:0] r;
        r = $random(seed);
        return r[23:0];
    endfunction

    task automatic apbAccess(input logic write, input regPkg::regAddrT addr,
                             input regPkg::regDataT wdata, output regPkg::regDataT rdata,
                             output logic err);
        @(negedge CLK);
        pSel    = 1'b1;
        pEnable = 1'b0;
        pWrite  = write;
        pAddr   = addr;
        pWData  = wdata;
        @(negedge CLK);
        pEnable = 1'b1;
        #1;
        rdata = pRData;
        err   = pSlvErr;
        @(negedge CLK);
        pSel    = 1'b0;
        pEnable = 1'b0;
        pWrite  = 1'b0;
    endtask

    task automatic writeReg(input regPkg::regAddrT addr, input regPkg::regDataT data,
                            input logic expErr);
        regPkg::regDataT rd;
        logic err;
        apbAccess(1'b1, addr, data, rd, err);
        assert (err == expErr) else begin
            errors++;
            $display("FAILED at %0t: write 0x%h pSlvErr %b expected %b", $time, addr, err, expErr);
        end
    endtask

    task automatic checkRead(input regPkg::regAddrT addr, input regPkg::regDataT expData,
                             input logic expErr);
        regPkg::regDataT rd;
        logic err;
        apbAccess(1'b0, addr, '0, rd, err);
        assert (rd == expData && err == expErr) else begin
            errors++;
            $display("FAILED at %0t: read 0x%h got %h/%b expected %h/%b",
                     $time, addr, rd, err, expData, expErr);
        end
    endtask

    task automatic setLayer(input int i, input logic [31:0] rect, input displayPkg::colourT c,
                            input logic en);
        writeReg(layerAddr(i, 0), rect, 1'b0);
        writeReg(layerAddr(i, 4), {8'd0, c}, 1'b0);
        writeReg(layerAddr(i, 8), {31'd0, en}, 1'b0);
        pendRect[i]   = rect;
        pendColour[i] = c;
        pendEn[i]     = en;
    endtask

    task automatic setBg(input displayPkg::colourT c);
        writeReg(`REG_BG, {8'd0, c}, 1'b0);
        pendBg = c;
    endtask

    // Some rows into the active area of frame n
    task automatic waitMidFrame(input int n);
        while (!(frameNo == n && lc >= `DISP_VBACK + 2)) begin
            @(negedge CLK);
        end
    endtask

    always @(negedge CLK) begin
        int x;
        int y;
        displayPkg::colourT expColour;
        if (hwVSync && !prevV) begin
            frameNo = frameNo + 1;
            lc = 0;
            hc = 0;
            actBg = pendBg;
            for (int i = 0; i < LAYERS; i++) begin
                actRect[i]   = pendRect[i];
                actColour[i] = pendColour[i];
                actEn[i]     = pendEn[i];
            end
        end else if (hwHSync && !prevH) begin
            lc = lc + 1;
            hc = 0;
        end else begin
            hc = hc + 1;
        end
        prevH = hwHSync;
        prevV = hwVSync;
        x = hc - `DISP_HBACK;
        y = lc - `DISP_VBACK;
        if (checkPixels && frameNo >= 2 && x >= 0 && x < `DISP_HDISP && y >= 0 &&
            y < `DISP_VDISP) begin
            expColour = refColour(x, y);
            assert (hwRgb == expColour) else begin
                errors++;
                $display("FAILED at %0t: pixel (%0d,%0d) got %h expected %h",
                         $time, x, y, hwRgb, expColour);
            end
        end
    end

    initial begin
        logic [31:0] v;
        logic [31:0] bgKept;
        logic [31:0] r0;
        logic [31:0] r1;
        logic expColl;
        seed = 57;
        errors = 0;
        cycles = 0;
        frameNo = 0;
        hc = 0;
        lc = 0;
        prevH = 1'b0;
        prevV = 1'b0;
        checkPixels = 1'b0;
        RESET = 1'b0;
        pSel = 1'b0;
        pEnable = 1'b0;
        pWrite = 1'b0;
        pAddr = '0;
        pWData = '0;
        repeat (5) @(negedge CLK);
        RESET = 1'b1;

        checkRead(`REG_STATUS, 32'd0, 1'b0);
        assert (hwDisp == 1'b0) else begin
            errors++;
            $display("FAILED at %0t: hwDisp high with the panel disabled", $time);
        end

        // Readback masked to field widths
        v = $random(seed);
        writeReg(`REG_CTRL, v & ~32'h1, 1'b0);
        checkRead(`REG_CTRL, 32'd0, 1'b0);
        v = $random(seed);
        writeReg(`REG_BG, v, 1'b0);
        checkRead(`REG_BG, v & 32'h00FF_FFFF, 1'b0);
        bgKept = v & 32'h00FF_FFFF;
        for (int i = 0; i < LAYERS; i++) begin
            v = $random(seed);
            writeReg(layerAddr(i, 0), v, 1'b0);
            checkRead(layerAddr(i, 0), v, 1'b0);
            v = $random(seed);
            writeReg(layerAddr(i, 4), v, 1'b0);
            checkRead(layerAddr(i, 4), v & 32'h00FF_FFFF, 1'b0);
            v = $random(seed);
            writeReg(layerAddr(i, 8), v, 1'b0);
            checkRead(layerAddr(i, 8), {31'd0, v[0]}, 1'b0);
        end

        // Unmapped addresses
        writeReg(8'h0C, 32'hFFFF_FFFF, 1'b1);
        checkRead(8'h0C, 32'd0, 1'b1);
        checkRead(layerAddr(0, 12), 32'd0, 1'b1);
        checkRead(layerAddr(LAYERS, 0), 32'd0, 1'b1);
        checkRead(8'hFC, 32'd0, 1'b1);
        checkRead(`REG_BG, bgKept, 1'b0);

        // Background only
        setBg(randColour());
        for (int i = 0; i < LAYERS; i++) begin
            setLayer(i, randRect(), randColour(), 1'b0);
        end
        writeReg(`REG_CTRL, 32'd1, 1'b0);
        checkRead(`REG_CTRL, 32'd1, 1'b0);
        assert (hwDisp == 1'b1) else begin
            errors++;
            $display("FAILED at %0t: hwDisp low with the panel enabled", $time);
        end
        checkPixels = 1'b1;

        // Overlapping layers written mid-frame show up one frame later
        waitMidFrame(3);
        r0 = randRect();
        r1 = randRect();
        if (!(r0[7:0] <= r1[23:16] && r1[7:0] <= r0[23:16] &&
              r0[15:8] <= r1[31:24] && r1[15:8] <= r0[31:24])) begin
            r1 = r0;
        end
        setBg(randColour());
        setLayer(0, r0, randColour(), 1'b1);
        setLayer(1, r1, randColour(), 1'b1);
        setLayer(2, randRect(), randColour(), 1'b1);
        expColl = pendOverlap();

        waitMidFrame(5);
        checkRead(`REG_STATUS, {31'd0, expColl}, 1'b0);

        // Side by side layers without overlap
        setBg(randColour());
        setLayer(0, {8'd7, 8'd3, 8'd0, 8'd0}, randColour(), 1'b1);
        setLayer(1, {8'd7, 8'd11, 8'd0, 8'd8}, randColour(), 1'b1);
        setLayer(2, randRect(), randColour(), 1'b0);
        expColl = pendOverlap();

        waitMidFrame(6);
        writeReg(`REG_STATUS, 32'd1, 1'b0);
        checkRead(`REG_STATUS, 32'd0, 1'b0);
        waitMidFrame(7);
        checkRead(`REG_STATUS, {31'd0, expColl}, 1'b0);

        $display("Errors: %0d value mismatches, %0d assertion failures",
                 errors, dut.chk.failures);
        if (errors == 0 && dut.chk.failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verif/overlay_checker.sv ====
`timescale 1ns/1ns
`include "display_params.svh"

module overlayChecker (
    input logic               CLK,
    input logic               RESET,
    input logic               hwDisp,
    input logic               hwHSync,
    input logic               hwVSync,
    input displayPkg::colourT hwRgb,
    input logic               panelEn,
    input logic               pixValid,
    input displayPkg::colourT mixColour,
    input logic               pSlvErr,
    input regPkg::regDataT    pRData
);

    localparam int LINE  = `DISP_HBACK + `DISP_HDISP + `DISP_HFRONT;
    localparam int FRAME = LINE * (`DISP_VBACK + `DISP_VDISP + `DISP_VFRONT);

    int failures;
    logic hSyncQ;
    logic vSyncQ;
    int hSince;
    int vSince;
    int hHigh;
    int vHigh;
    int vFalls;
    logic settled;

    // Pulse lengths and spacing, sampled like the assertions sample them
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            hSyncQ <= 1'b0;
            vSyncQ <= 1'b0;
            hSince <= 0;
            vSince <= 0;
            hHigh  <= 0;
            vHigh  <= 0;
            vFalls <= 0;
        end else begin
            hSyncQ <= hwHSync;
            vSyncQ <= hwVSync;
            hSince <= (hwHSync && !hSyncQ) ? 1 : hSince + 1;
            vSince <= (hwVSync && !vSyncQ) ? 1 : vSince + 1;
            hHigh  <= hwHSync ? hHigh + 1 : 0;
            vHigh  <= hwVSync ? vHigh + 1 : 0;
            if (!hwVSync && vSyncQ && vFalls < 2) begin
                vFalls <= vFalls + 1;
            end
        end
    end

    // First frame after enable starts from the reset state of the sync pipeline
    assign settled = vFalls == 2;

    hSyncPeriod: assert property (@(posedge CLK) disable iff (!RESET || !settled)
        (hwHSync && !hSyncQ) |-> hSince == LINE)
        else begin $error("hwHSync period differs from %0d cycles", LINE); failures++; end

    hSyncWidth: assert property (@(posedge CLK) disable iff (!RESET || !settled)
        (!hwHSync && hSyncQ) |-> hHigh == `DISP_HSYNC)
        else begin $error("hwHSync pulse width wrong"); failures++; end

    vSyncPeriod: assert property (@(posedge CLK) disable iff (!RESET || !settled)
        (hwVSync && !vSyncQ) |-> vSince == FRAME)
        else begin $error("hwVSync period differs from %0d cycles", FRAME); failures++; end

    vSyncWidth: assert property (@(posedge CLK) disable iff (!RESET || !settled)
        (!hwVSync && vSyncQ) |-> vHigh == `DISP_VSYNC * LINE)
        else begin $error("hwVSync pulse width wrong"); failures++; end

    dispFollowsEn: assert property (@(posedge CLK) disable iff (!RESET)
        hwDisp == $past(panelEn))
        else begin $error("hwDisp does not follow the panel enable"); failures++; end

    rgbCapture: assert property (@(posedge CLK) disable iff (!RESET)
        (panelEn && pixValid) |=> hwRgb == $past(mixColour))
        else begin $error("hwRgb missed the mixed colour"); failures++; end

    rgbHold: assert property (@(posedge CLK) disable iff (!RESET || !settled)
        !$stable(hwRgb) |-> $past(panelEn && pixValid))
        else begin $error("hwRgb changed outside a displayed cycle"); failures++; end

    errReadsZero: assert property (@(posedge CLK) disable iff (!RESET)
        pSlvErr |-> pRData == '0)
        else begin $error("pRData not zero on a slave error"); failures++; end

endmodule

bind overlayTop overlayChecker chk (
    .CLK       (CLK),
    .RESET     (RESET),
    .hwDisp    (hwDisp),
    .hwHSync   (hwHSync),
    .hwVSync   (hwVSync),
    .hwRgb     (hwRgb),
    .panelEn   (panelEn),
    .pixValid  (pixValid),
    .mixColour (mixColour),
    .pSlvErr   (pSlvErr),
    .pRData    (pRData)
);

// ==== hw/overlayTop.sv ====
`timescale 1ns/1ns
`include "display_params.svh"

module overlayTop (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               pSel,
    input  logic               pEnable,
    input  logic               pWrite,
    input  regPkg::regAddrT    pAddr,
    input  regPkg::regDataT    pWData,
    output regPkg::regDataT    pRData,
    output logic               pSlvErr,
    output logic               hwDclk,
    output logic               hwDisp,
    output logic               hwVSync,
    output logic               hwHSync,
    output displayPkg::colourT hwRgb
);

    logic panelEn;
    displayPkg::colourT bgColour;
    logic [`DISP_LAYERS-1:0][regPkg::RECT_W-1:0] rectCfg;
    displayPkg::colourT [`DISP_LAYERS-1:0] layerColour;
    logic [`DISP_LAYERS-1:0] layerEn;
    logic collisionClr;
    logic collision;

    logic hBlank;
    logic vBlank;
    displayPkg::xCoordT pixX;
    displayPkg::yCoordT pixY;
    logic pixValid;
    logic frameStart;

    logic [`DISP_LAYERS-1:0] hits;
    displayPkg::colourT [`DISP_LAYERS-1:0] layerColours;
    displayPkg::colourT mixColour;

    apbRegs regs (
        .CLK          (CLK),
        .RESET        (RESET),
        .pSel         (pSel),
        .pEnable      (pEnable),
        .pWrite       (pWrite),
        .pAddr        (pAddr),
        .pWData       (pWData),
        .pRData       (pRData),
        .pSlvErr      (pSlvErr),
        .panelEn      (panelEn),
        .bgColour     (bgColour),
        .rectCfg      (rectCfg),
        .layerColour  (layerColour),
        .layerEn      (layerEn),
        .collisionClr (collisionClr),
        .collision    (collision)
    );

    pixelScanner scanner (
        .CLK        (CLK),
        .RESET      (RESET),
        .hBlank     (hBlank),
        .vBlank     (vBlank),
        .pixX       (pixX),
        .pixY       (pixY),
        .pixValid   (pixValid),
        .frameStart (frameStart)
    );

    for (genvar i = 0; i < `DISP_LAYERS; i++) begin : genLayers
        rectLayer layer (
            .CLK         (CLK),
            .RESET       (RESET),
            .frameStart  (frameStart),
            .rectCfg     (rectCfg[i]),
            .layerColour (layerColour[i]),
            .layerEn     (layerEn[i]),
            .pixX        (pixX),
            .pixY        (pixY),
            .hit         (hits[i]),
            .colour      (layerColours[i])
        );
    end

    layerMixer mixer (
        .CLK          (CLK),
        .RESET        (RESET),
        .frameStart   (frameStart),
        .pixValid     (pixValid),
        .hits         (hits),
        .layerColours (layerColours),
        .bgColour     (bgColour),
        .collisionClr (collisionClr),
        .colour       (mixColour),
        .collision    (collision)
    );

    tftTiming #(
        .WIDTH ($bits(displayPkg::colourT))
    ) timing (
        .CLK     (CLK),
        .RESET   (RESET),
        .en      (panelEn),
        .hBlank  (hBlank),
        .vBlank  (vBlank),
        .colour  (mixColour),
        .hwDclk  (hwDclk),
        .hwDisp  (hwDisp),
        .hwVSync (hwVSync),
        .hwHSync (hwHSync),
        .hwRgb   (hwRgb)
    );

endmodule

// ==== hw/layerMixer.sv ====
`timescale 1ns/1ns
`include "display_params.svh"

module layerMixer (
    input  logic                                  CLK,
    input  logic                                  RESET,
    input  logic                                  frameStart,
    input  logic                                  pixValid,
    input  logic [`DISP_LAYERS-1:0]               hits,
    input  displayPkg::colourT [`DISP_LAYERS-1:0] layerColours,
    input  displayPkg::colourT                    bgColour,
    input  logic                                  collisionClr,
    output displayPkg::colourT                    colour,
    output logic                                  collision
);

    displayPkg::colourT bgShadow;
    logic multiHit;

    // Background follows the same frame boundary as the layers
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            bgShadow <= '0;
        end else if (frameStart) begin
            bgShadow <= bgColour;
        end
    end

    // Later layers overwrite earlier ones
    always_comb begin
        colour = bgShadow;
        for (int i = 0; i < `DISP_LAYERS; i++) begin
            if (hits[i]) begin
                colour = layerColours[i];
            end
        end
    end

    assign multiHit = $countones(hits) > 1;

    // Set beats clear when both land together
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            collision <= 1'b0;
        end else if (pixValid && multiHit) begin
            collision <= 1'b1;
        end else if (collisionClr) begin
            collision <= 1'b0;
        end
    end

endmodule

// ==== hw/rectLayer.sv ====
`timescale 1ns/1ns

module rectLayer (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      frameStart,
    input  logic [regPkg::RECT_W-1:0] rectCfg,
    input  displayPkg::colourT        layerColour,
    input  logic                      layerEn,
    input  displayPkg::xCoordT        pixX,
    input  displayPkg::yCoordT        pixY,
    output logic                      hit,
    output displayPkg::colourT        colour
);

    logic [regPkg::RECT_W-1:0] rectShadow;
    displayPkg::colourT colourShadow;
    logic enShadow;
    displayPkg::xCoordT x0;
    displayPkg::xCoordT x1;
    displayPkg::yCoordT y0;
    displayPkg::yCoordT y1;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            enShadow <= 1'b0;
        end else if (frameStart) begin
            enShadow <= layerEn;
        end
    end

    // Bounds and colour change only between frames
    always_ff @(posedge CLK) begin
        if (frameStart) begin
            rectShadow   <= rectCfg;
            colourShadow <= layerColour;
        end
    end

    assign x0 = rectShadow[7:0];
    assign y0 = rectShadow[15:8];
    assign x1 = rectShadow[23:16];
    assign y1 = rectShadow[31:24];

    // Inclusive on all four edges
    assign hit = enShadow && (pixX >= x0) && (pixX <= x1) && (pixY >= y0) && (pixY <= y1);

    assign colour = colourShadow;

endmodule

// ==== hw/pixelScanner.sv ====
`timescale 1ns/1ns

module pixelScanner (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               hBlank,
    input  logic               vBlank,
    output displayPkg::xCoordT pixX,
    output displayPkg::yCoordT pixY,
    output logic               pixValid,
    output logic               frameStart
);

    logic hBlankQ;
    logic vBlankQ;

    assign pixValid = !hBlank && !vBlank;

    // Rising edge of vertical blanking
    assign frameStart = vBlank && !vBlankQ;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            hBlankQ <= 1'b1;
            vBlankQ <= 1'b1;
            pixX    <= '0;
            pixY    <= '0;
        end else begin
            hBlankQ <= hBlank;
            vBlankQ <= vBlank;

            if (hBlank) begin
                pixX <= '0;
            end else if (pixValid) begin
                pixX <= pixX + 1'b1;
            end

            // Next row once the active part of a line ends
            if (vBlank) begin
                pixY <= '0;
            end else if (hBlank && !hBlankQ) begin
                pixY <= pixY + 1'b1;
            end
        end
    end

endmodule

// ==== hw/tftTiming.sv ====
`timescale 1ns/1ns
`include "display_params.svh"

module tftTiming #(
    parameter int WIDTH = 24
) (
    input  logic             CLK,
    input  logic             RESET,
    input  logic             en,
    output logic             hBlank,
    output logic             vBlank,
    input  logic [WIDTH-1:0] colour,
    output logic             hwDclk,
    output logic             hwDisp,
    output logic             hwVSync,
    output logic             hwHSync,
    output logic [WIDTH-1:0] hwRgb
);

    // Sync pulses overlap the back porch
    localparam int HSYNC  = `DISP_HSYNC;
    localparam int HBACK  = `DISP_HBACK;
    localparam int HDISP  = `DISP_HDISP;
    localparam int HFRONT = `DISP_HFRONT;
    localparam int VSYNC  = `DISP_VSYNC;
    localparam int VBACK  = `DISP_VBACK;
    localparam int VDISP  = `DISP_VDISP;
    localparam int VFRONT = `DISP_VFRONT;

    localparam int HTOTAL = HBACK + HDISP + HFRONT;
    localparam int VTOTAL = VBACK + VDISP + VFRONT;
    localparam int HN     = $clog2(HTOTAL);
    localparam int VN     = $clog2(VTOTAL);

    logic [HN-1:0] hCount;
    logic hSync;
    logic hDisp;
    logic hEnd;
    logic hSyncQ;

    logic [VN-1:0] vCount;
    logic vSync;
    logic vDisp;
    logic vEnd;
    logic vSyncQ;

    // Horizontal counter
    assign hSync = hCount < HN'(HSYNC);
    assign hDisp = (hCount >= HN'(HBACK)) && (hCount < HN'(HBACK + HDISP));
    assign hEnd  = hCount == HN'(HTOTAL - 1);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            hCount <= '0;
            hBlank <= 1'b1;
            hSyncQ <= 1'b1;
        end else if (en) begin
            if (hEnd) begin
                hCount <= '0;
            end else begin
                hCount <= hCount + 1'b1;
            end
            hBlank <= ~hDisp;
            hSyncQ <= hSync;
        end
    end

    // Vertical counter steps at the end of each line
    assign vSync = vCount < VN'(VSYNC);
    assign vDisp = (vCount >= VN'(VBACK)) && (vCount < VN'(VBACK + VDISP));
    assign vEnd  = vCount == VN'(VTOTAL - 1);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            vCount <= '0;
            vBlank <= 1'b1;
            vSyncQ <= 1'b1;
        end else if (en) begin
            if (hEnd && vEnd) begin
                vCount <= '0;
            end else if (hEnd) begin
                vCount <= vCount + 1'b1;
            end
            vBlank <= ~vDisp;
            vSyncQ <= vSync;
        end
    end

    assign hwDclk = CLK;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            hwDisp <= 1'b0;
        end else begin
            hwDisp <= en;
        end
    end

    // Second sync stage lines up with the RGB register
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            hwHSync <= 1'b0;
            hwVSync <= 1'b0;
        end else if (en) begin
            hwHSync <= hSyncQ;
            hwVSync <= vSyncQ;
        end
    end

    // Pixel data only moves in displayed cycles
    always_ff @(posedge CLK) begin
        if (en && !hBlank && !vBlank) begin
            hwRgb <= colour;
        end
    end

endmodule

// ==== hw/apbRegs.sv ====
`timescale 1ns/1ns
`include "display_params.svh"

module apbRegs (
    input  logic                                          CLK,
    input  logic                                          RESET,
    input  logic                                          pSel,
    input  logic                                          pEnable,
    input  logic                                          pWrite,
    input  regPkg::regAddrT                               pAddr,
    input  regPkg::regDataT                               pWData,
    output regPkg::regDataT                               pRData,
    output logic                                          pSlvErr,
    output logic                                          panelEn,
    output displayPkg::colourT                            bgColour,
    output logic [`DISP_LAYERS-1:0][regPkg::RECT_W-1:0]   rectCfg,
    output displayPkg::colourT [`DISP_LAYERS-1:0]         layerColour,
    output logic [`DISP_LAYERS-1:0]                       layerEn,
    output logic                                          collisionClr,
    input  logic                                          collision
);

    localparam int COLOUR_W = $bits(displayPkg::colourT);
    localparam int DATA_W   = regPkg::DATA_W;

    logic selCtrl;
    logic selBg;
    logic selStatus;
    logic [`DISP_LAYERS-1:0] selRect;
    logic [`DISP_LAYERS-1:0] selColour;
    logic [`DISP_LAYERS-1:0] selEn;
    logic mapped;
    logic access;
    logic wrAccess;
    regPkg::regDataT [`DISP_LAYERS-1:0] layerRData;

    // Global registers
    assign selCtrl   = pAddr == `REG_CTRL;
    assign selBg     = pAddr == `REG_BG;
    assign selStatus = pAddr == `REG_STATUS;

    // One address block per layer
    for (genvar i = 0; i < `DISP_LAYERS; i++) begin : genLayerDecode
        localparam regPkg::regAddrT BASE =
            regPkg::regAddrT'(`REG_LAYER_BASE + i * `REG_LAYER_STRIDE);

        assign selRect[i]   = pAddr == BASE + `REG_LAYER_RECT;
        assign selColour[i] = pAddr == BASE + `REG_LAYER_COLOUR;
        assign selEn[i]     = pAddr == BASE + `REG_LAYER_EN;

        assign layerRData[i] =
            (selRect[i] ? regPkg::regDataT'(rectCfg[i]) : '0) |
            (selColour[i] ? {{(DATA_W-COLOUR_W){1'b0}}, layerColour[i]} : '0) |
            (selEn[i] ? {{(DATA_W-regPkg::EN_W){1'b0}}, layerEn[i]} : '0);
    end

    assign mapped = selCtrl | selBg | selStatus | (|selRect) | (|selColour) | (|selEn);

    assign access   = pSel & pEnable;
    assign wrAccess = access & pWrite & mapped;
    assign pSlvErr  = access & ~mapped;

    // Sticky flag clears on a write of 1
    assign collisionClr = wrAccess & selStatus & pWData[regPkg::COLLISION_BIT];

    // Unmapped addresses fall through to zero
    always_comb begin
        pRData = '0;
        if (selCtrl) begin
            pRData = {{(DATA_W-regPkg::CTRL_W){1'b0}}, panelEn};
        end
        if (selBg) begin
            pRData = {{(DATA_W-COLOUR_W){1'b0}}, bgColour};
        end
        if (selStatus) begin
            pRData[regPkg::COLLISION_BIT] = collision;
        end
        for (int i = 0; i < `DISP_LAYERS; i++) begin
            pRData = pRData | layerRData[i];
        end
        if (!access) begin
            pRData = '0;
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            panelEn     <= 1'b0;
            bgColour    <= '0;
            rectCfg     <= '0;
            layerColour <= '0;
            layerEn     <= '0;
        end else if (wrAccess) begin
            if (selCtrl) begin
                panelEn <= pWData[regPkg::CTRL_W-1:0];
            end
            if (selBg) begin
                bgColour <= pWData[COLOUR_W-1:0];
            end
            for (int i = 0; i < `DISP_LAYERS; i++) begin
                if (selRect[i]) begin
                    rectCfg[i] <= pWData[regPkg::RECT_W-1:0];
                end
                if (selColour[i]) begin
                    layerColour[i] <= pWData[COLOUR_W-1:0];
                end
                if (selEn[i]) begin
                    layerEn[i] <= pWData[regPkg::EN_W-1:0];
                end
            end
        end
    end

endmodule

// ==== hw/regPkg.sv ====
package regPkg;

    // APB bus widths
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] regAddrT;
    typedef logic [DATA_W-1:0] regDataT;

    // Rectangle word, x0 y0 x1 y1 from byte 0 up
    localparam int RECT_W = 32;

    // Single-bit fields
    localparam int CTRL_W = 1;
    localparam int EN_W   = 1;

    // Status register bit positions
    localparam int COLLISION_BIT = 0;

endpackage

// ==== hw/displayPkg.sv ====
package displayPkg;

    // Colour depth of the panel bus
    localparam int COLOUR_W = 24;

    // Coordinates fit the small test panel with room to spare
    localparam int COORD_W = 8;

    // Red in the top byte, blue in the bottom byte
    typedef logic [COLOUR_W-1:0] colourT;

    // Column of the current pixel
    typedef logic [COORD_W-1:0] xCoordT;

    // Row of the current pixel
    typedef logic [COORD_W-1:0] yCoordT;

endpackage

// ==== hw/display_params.svh ====
`ifndef DISPLAY_PARAMS_SVH
`define DISPLAY_PARAMS_SVH

// Horizontal timing in pixel clocks, sync overlaps the back porch
`define DISP_HSYNC  2
`define DISP_HBACK  4
`define DISP_HDISP  16
`define DISP_HFRONT 2

// Vertical timing in lines
`define DISP_VSYNC  1
`define DISP_VBACK  2
`define DISP_VDISP  8
`define DISP_VFRONT 1

// Rectangle layers, highest index has priority
`define DISP_LAYERS 3

// Register byte addresses
`define REG_CTRL         8'h00
`define REG_BG           8'h04
`define REG_STATUS       8'h08
`define REG_LAYER_BASE   8'h10
`define REG_LAYER_STRIDE 8'h10

// Offsets within one layer block
`define REG_LAYER_RECT   8'h00
`define REG_LAYER_COLOUR 8'h04
`define REG_LAYER_EN     8'h08

`endif
